/* logic/coreIsaPkg.sv */
`default_nettype none

package coreIsaPkg;

    localparam int Xlen     = 32;
    localparam int RegAddrW = 5;

    // base opcodes that this core decodes
    typedef enum logic [6:0] {
        opOp     = 7'b0110011,
        opImm    = 7'b0010011,
        opLui    = 7'b0110111,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111
    } opcodeE;

    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Srl    = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Bne    = 3'b001;
    localparam logic [6:0] f7Sub    = 7'b0100000;

    typedef struct packed {
        logic [6:0]          funct7;
        logic [RegAddrW-1:0] rs2;
        logic [RegAddrW-1:0] rs1;
        logic [2:0]          funct3;
        logic [RegAddrW-1:0] rd;
        opcodeE              opcode;
    } rFormat;

    typedef struct packed {
        logic [11:0]         imm;
        logic [RegAddrW-1:0] rs1;
        logic [2:0]          funct3;
        logic [RegAddrW-1:0] rd;
        opcodeE              opcode;
    } iFormat;

    // branch offset is scattered over two fields
    typedef struct packed {
        logic                imm12;
        logic [5:0]          imm10to5;
        logic [RegAddrW-1:0] rs2;
        logic [RegAddrW-1:0] rs1;
        logic [2:0]          funct3;
        logic [3:0]          imm4to1;
        logic                imm11;
        opcodeE              opcode;
    } bFormat;

    typedef struct packed {
        logic [19:0]         imm;
        logic [RegAddrW-1:0] rd;
        opcodeE              opcode;
    } uFormat;

    typedef struct packed {
        logic                imm20;
        logic [9:0]          imm10to1;
        logic                imm11;
        logic [7:0]          imm19to12;
        logic [RegAddrW-1:0] rd;
        opcodeE              opcode;
    } jFormat;

    // one word, five views
    typedef union packed {
        rFormat rType;
        iFormat iType;
        bFormat bType;
        uFormat uType;
        jFormat jType;
    } instWord;

endpackage

`default_nettype wire

/* logic/corePipePkg.sv */
`default_nettype none

package corePipePkg;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluSrl,
        aluPassB
    } aluOpE;

    // decode to execute
    typedef struct packed {
        logic                            valid;
        logic [coreIsaPkg::Xlen-1:0]     pc;
        logic [coreIsaPkg::RegAddrW-1:0] rs1;
        logic [coreIsaPkg::RegAddrW-1:0] rs2;
        logic [coreIsaPkg::RegAddrW-1:0] rd;
        logic [coreIsaPkg::Xlen-1:0]     rs1Val;
        logic [coreIsaPkg::Xlen-1:0]     rs2Val;
        logic [coreIsaPkg::Xlen-1:0]     imm;
        aluOpE                           aluOp;
        logic                            useImm;
        logic                            isBranch;
        logic                            branchNe;
        logic                            isJal;
        logic                            writesRd;
    } decodeToExec;

    // execute to result, also the writeback forward
    typedef struct packed {
        logic                            valid;
        logic [coreIsaPkg::RegAddrW-1:0] rd;
        logic                            writesRd;
        logic [coreIsaPkg::Xlen-1:0]     result;
    } execToResult;

    typedef struct packed {
        logic                        taken;
        logic [coreIsaPkg::Xlen-1:0] target;
    } redirect;

endpackage

`default_nettype wire

/* logic/fetchUnit.sv */
`default_nettype none

module fetchUnit #(
    parameter logic [coreIsaPkg::Xlen-1:0] ResetPc = '0
) (
    input  logic                        clock,
    input  logic                        rstN,
    input  corePipePkg::redirect        redir,
    output logic [coreIsaPkg::Xlen-1:0] pc
);

    // redirect from execute wins over the sequential step
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pc <= ResetPc;
        end else if (redir.taken) begin
            pc <= redir.target;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    // targets come from decoded offsets, so misalignment would mean a bad immediate build
    pcAligned: assert property (
        @(posedge clock) disable iff (!rstN)
        pc[1:0] == 2'b00
    );

endmodule

`default_nettype wire

/* logic/decodeUnit.sv */
`default_nettype none

module decodeUnit (
    input  logic                            clock,
    input  logic                            rstN,
    input  logic [coreIsaPkg::Xlen-1:0]     pc,
    input  logic [coreIsaPkg::Xlen-1:0]     inst,
    input  corePipePkg::redirect            redir,
    output logic [coreIsaPkg::RegAddrW-1:0] rs1Addr,
    output logic [coreIsaPkg::RegAddrW-1:0] rs2Addr,
    input  logic [coreIsaPkg::Xlen-1:0]     rs1Val,
    input  logic [coreIsaPkg::Xlen-1:0]     rs2Val,
    output corePipePkg::decodeToExec        dx
);

    logic                        idValid;
    logic [coreIsaPkg::Xlen-1:0] idPc;
    coreIsaPkg::instWord         idInst;

    // fetch always delivers, only a redirect empties this slot
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            idValid <= 1'b0;
        end else begin
            idValid <= !redir.taken;
        end
    end

    always_ff @(posedge clock) begin
        idPc   <= pc;
        idInst <= inst;
    end

    // rs1/rs2 sit at the same bits in every format that has them
    assign rs1Addr = idInst.rType.rs1;
    assign rs2Addr = idInst.rType.rs2;

    function automatic corePipePkg::aluOpE aluFromFunct(
        input logic [2:0] funct3,
        input logic       isSub
    );
        case (funct3)
            coreIsaPkg::f3AddSub: return isSub ? corePipePkg::aluSub : corePipePkg::aluAdd;
            coreIsaPkg::f3Sll:    return corePipePkg::aluSll;
            coreIsaPkg::f3Slt:    return corePipePkg::aluSlt;
            coreIsaPkg::f3Xor:    return corePipePkg::aluXor;
            coreIsaPkg::f3Srl:    return corePipePkg::aluSrl;
            coreIsaPkg::f3Or:     return corePipePkg::aluOr;
            coreIsaPkg::f3And:    return corePipePkg::aluAnd;
            default:              return corePipePkg::aluAdd;
        endcase
    endfunction

    always_comb begin
        dx        = '0;
        dx.valid  = idValid;
        dx.pc     = idPc;
        dx.rs1    = rs1Addr;
        dx.rs2    = rs2Addr;
        dx.rd     = idInst.rType.rd;
        dx.rs1Val = rs1Val;
        dx.rs2Val = rs2Val;
        dx.aluOp  = corePipePkg::aluAdd;
        case (idInst.rType.opcode)
            coreIsaPkg::opOp: begin
                dx.aluOp    = aluFromFunct(idInst.rType.funct3,
                                           idInst.rType.funct7 == coreIsaPkg::f7Sub);
                dx.writesRd = 1'b1;
            end
            coreIsaPkg::opImm: begin
                dx.imm      = {{20{idInst.iType.imm[11]}}, idInst.iType.imm};
                dx.aluOp    = aluFromFunct(idInst.iType.funct3, 1'b0);
                dx.useImm   = 1'b1;
                dx.writesRd = 1'b1;
            end
            coreIsaPkg::opLui: begin
                dx.imm      = {idInst.uType.imm, 12'b0};
                dx.aluOp    = corePipePkg::aluPassB;
                dx.useImm   = 1'b1;
                dx.writesRd = 1'b1;
            end
            coreIsaPkg::opBranch: begin
                dx.imm      = {{19{idInst.bType.imm12}}, idInst.bType.imm12,
                               idInst.bType.imm11, idInst.bType.imm10to5,
                               idInst.bType.imm4to1, 1'b0};
                dx.isBranch = 1'b1;
                dx.branchNe = idInst.bType.funct3 == coreIsaPkg::f3Bne;
            end
            coreIsaPkg::opJal: begin
                dx.imm      = {{11{idInst.jType.imm20}}, idInst.jType.imm20,
                               idInst.jType.imm19to12, idInst.jType.imm11,
                               idInst.jType.imm10to1, 1'b0};
                dx.isJal    = 1'b1;
                dx.writesRd = 1'b1;
            end
            // anything else flows on as a bubble
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* logic/executeUnit.sv */
`default_nettype none

module executeUnit (
    input  logic                     clock,
    input  logic                     rstN,
    input  corePipePkg::decodeToExec dx,
    input  corePipePkg::execToResult wbFwd,
    output corePipePkg::redirect     redir,
    output corePipePkg::execToResult xr
);

    logic                        exValid;
    corePipePkg::decodeToExec    dxQ;
    logic                        fwdA;
    logic                        fwdB;
    logic [coreIsaPkg::Xlen-1:0] opA;
    logic [coreIsaPkg::Xlen-1:0] opB;
    logic [coreIsaPkg::Xlen-1:0] aluB;
    logic [coreIsaPkg::Xlen-1:0] aluOut;
    logic                        branchTaken;

    // the entry behind a taken branch or jal is the first one lost
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            exValid <= 1'b0;
        end else begin
            exValid <= dx.valid && !redir.taken;
        end
    end

    always_ff @(posedge clock) begin
        dxQ <= dx;
    end

    // writeback register holds the one result the register file missed
    assign fwdA = wbFwd.valid && wbFwd.writesRd && (wbFwd.rd != '0) && (wbFwd.rd == dxQ.rs1);
    assign fwdB = wbFwd.valid && wbFwd.writesRd && (wbFwd.rd != '0) && (wbFwd.rd == dxQ.rs2);

    assign opA  = fwdA ? wbFwd.result : dxQ.rs1Val;
    assign opB  = fwdB ? wbFwd.result : dxQ.rs2Val;
    assign aluB = dxQ.useImm ? dxQ.imm : opB;

    always_comb begin
        case (dxQ.aluOp)
            corePipePkg::aluAdd:   aluOut = opA + aluB;
            corePipePkg::aluSub:   aluOut = opA - aluB;
            corePipePkg::aluAnd:   aluOut = opA & aluB;
            corePipePkg::aluOr:    aluOut = opA | aluB;
            corePipePkg::aluXor:   aluOut = opA ^ aluB;
            corePipePkg::aluSlt:   aluOut = {31'b0, $signed(opA) < $signed(aluB)};
            corePipePkg::aluSll:   aluOut = opA << aluB[4:0];
            corePipePkg::aluSrl:   aluOut = opA >> aluB[4:0];
            corePipePkg::aluPassB: aluOut = aluB;
            default:               aluOut = '0;
        endcase
    end

    // beq when equal, bne when not
    assign branchTaken = dxQ.isBranch && ((opA == opB) != dxQ.branchNe);

    assign redir.taken  = exValid && (branchTaken || dxQ.isJal);
    assign redir.target = dxQ.pc + dxQ.imm;

    assign xr.valid    = exValid;
    assign xr.rd       = dxQ.rd;
    assign xr.writesRd = dxQ.writesRd;
    assign xr.result   = dxQ.isJal ? dxQ.pc + 32'd4 : aluOut;

    // the squashed entry behind a redirect must never steer fetch
    redirSquashesNext: assert property (
        @(posedge clock) disable iff (!rstN)
        redir.taken |=> !redir.taken
    );

endmodule

`default_nettype wire

/* logic/resultUnit.sv */
`default_nettype none

module resultUnit (
    input  logic                            clock,
    input  logic                            rstN,
    input  corePipePkg::execToResult        xr,
    input  logic [coreIsaPkg::RegAddrW-1:0] rs1Addr,
    input  logic [coreIsaPkg::RegAddrW-1:0] rs2Addr,
    output logic [coreIsaPkg::Xlen-1:0]     rs1Val,
    output logic [coreIsaPkg::Xlen-1:0]     rs2Val,
    output corePipePkg::execToResult        wbFwd,
    output logic                            retireValid,
    output logic [coreIsaPkg::RegAddrW-1:0] retireRd,
    output logic [coreIsaPkg::Xlen-1:0]     retireData
);

    logic                        wbValid;
    corePipePkg::execToResult    xrQ;
    logic                        wbWrite;
    logic [coreIsaPkg::Xlen-1:0] regFile [32];

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= xr.valid;
        end
    end

    always_ff @(posedge clock) begin
        xrQ <= xr;
        // x0 holds no value, so its result is dropped on capture
        if (xr.rd == '0) begin
            xrQ.result <= '0;
        end
    end

    // x0 is never written
    assign wbWrite = wbValid && xrQ.writesRd && (xrQ.rd != '0);

    always_ff @(posedge clock) begin
        if (wbWrite) begin
            regFile[xrQ.rd] <= xrQ.result;
        end
    end

    // reads see the value landing at this edge
    always_comb begin
        if (rs1Addr == '0) begin
            rs1Val = '0;
        end else if (wbWrite && (rs1Addr == xrQ.rd)) begin
            rs1Val = xrQ.result;
        end else begin
            rs1Val = regFile[rs1Addr];
        end
        if (rs2Addr == '0) begin
            rs2Val = '0;
        end else if (wbWrite && (rs2Addr == xrQ.rd)) begin
            rs2Val = xrQ.result;
        end else begin
            rs2Val = regFile[rs2Addr];
        end
    end

    assign wbFwd.valid    = wbValid;
    assign wbFwd.rd       = xrQ.rd;
    assign wbFwd.writesRd = xrQ.writesRd;
    assign wbFwd.result   = xrQ.result;

    assign retireValid = wbValid && xrQ.writesRd;
    assign retireRd    = xrQ.rd;
    assign retireData  = xrQ.result;

    x0RetiresZero: assert property (
        @(posedge clock) disable iff (!rstN)
        (retireValid && retireRd == '0) |-> retireData == '0
    );

endmodule

`default_nettype wire

/* logic/fireCore.sv */
`default_nettype none

module fireCore #(
    parameter logic [coreIsaPkg::Xlen-1:0] ResetPc = '0
) (
    input  logic                            clock,
    input  logic                            rstN,
    input  logic [coreIsaPkg::Xlen-1:0]     inst,
    output logic [coreIsaPkg::Xlen-1:0]     pc,
    output logic                            retireValid,
    output logic [coreIsaPkg::RegAddrW-1:0] retireRd,
    output logic [coreIsaPkg::Xlen-1:0]     retireData
);

    corePipePkg::redirect            redir;
    corePipePkg::decodeToExec        dx;
    corePipePkg::execToResult        xr;
    corePipePkg::execToResult        wbFwd;
    logic [coreIsaPkg::RegAddrW-1:0] rs1Addr;
    logic [coreIsaPkg::RegAddrW-1:0] rs2Addr;
    logic [coreIsaPkg::Xlen-1:0]     rs1Val;
    logic [coreIsaPkg::Xlen-1:0]     rs2Val;

    fetchUnit #(
        .ResetPc(ResetPc)
    ) uFetch (
        .clock(clock),
        .rstN (rstN),
        .redir(redir),
        .pc   (pc)
    );

    decodeUnit uDecode (
        .clock  (clock),
        .rstN   (rstN),
        .pc     (pc),
        .inst   (inst),
        .redir  (redir),
        .rs1Addr(rs1Addr),
        .rs2Addr(rs2Addr),
        .rs1Val (rs1Val),
        .rs2Val (rs2Val),
        .dx     (dx)
    );

    executeUnit uExecute (
        .clock(clock),
        .rstN (rstN),
        .dx   (dx),
        .wbFwd(wbFwd),
        .redir(redir),
        .xr   (xr)
    );

    resultUnit uResult (
        .clock      (clock),
        .rstN       (rstN),
        .xr         (xr),
        .rs1Addr    (rs1Addr),
        .rs2Addr    (rs2Addr),
        .rs1Val     (rs1Val),
        .rs2Val     (rs2Val),
        .wbFwd      (wbFwd),
        .retireValid(retireValid),
        .retireRd   (retireRd),
        .retireData (retireData)
    );

endmodule

`default_nettype wire

/* tests/coreTb.sv */
`default_nettype none

module coreTb;

    localparam logic [31:0] Nop           = 32'h00000013;
    localparam int          TimeoutCycles = 200;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] data;
    } retireRow;

    logic        clock;
    logic        rstN;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        retireValid;
    logic [4:0]  retireRd;
    logic [31:0] retireData;

    logic [31:0] rom [0:127];
    int          progLen;
    logic [31:0] shadow [0:31];
    string       testNames [$];
    retireRow    expected [$];
    int          seed;
    int          passCount;
    int          failCount;

    fireCore #(
        .ResetPc(32'h0)
    ) u_dut (
        .clock      (clock),
        .rstN       (rstN),
        .inst       (inst),
        .pc         (pc),
        .retireValid(retireValid),
        .retireRd   (retireRd),
        .retireData (retireData)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic logic [31:0] fetchWord(input logic [31:0] addr);
        logic [31:0] index;
        index = addr >> 2;
        if (index < progLen) begin
            return rom[index[6:0]];
        end else begin
            return Nop;
        end
    endfunction

    // instruction ROM, answers the pc set at the last rising edge
    always @(negedge clock) begin
        inst = fetchWord(pc);
    end

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // B and J offsets are scrambled across the word
    function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // RV32I result for an OP/OP-IMM funct3
    function automatic logic [31:0] expectedAlu(input logic [2:0] f3, input logic isSub,
                                                input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return isSub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic putWord(input logic [31:0] word);
        rom[progLen[6:0]] = word;
        progLen++;
    endtask

    // x0 is hardwired, so its retire carries zero
    task automatic expectRetire(input string name, input int rd, input logic [31:0] value);
        retireRow row;
        row.rd   = rd[4:0];
        row.data = (rd[4:0] == 5'd0) ? 32'd0 : value;
        testNames.push_back(name);
        expected.push_back(row);
        if (rd[4:0] != 5'd0) begin
            shadow[rd[4:0]] = value;
        end
    endtask

    task automatic doImm(input string name, input logic [2:0] f3, input int rd,
                         input int rs1, input int imm);
        logic [11:0] imm12;
        logic [31:0] immExt;
        imm12  = imm[11:0];
        immExt = {{20{imm12[11]}}, imm12};
        putWord(encI(imm12, rs1[4:0], f3, rd[4:0]));
        expectRetire(name, rd, expectedAlu(f3, 1'b0, shadow[rs1[4:0]], immExt));
    endtask

    task automatic doReg(input string name, input logic [2:0] f3, input logic isSub,
                         input int rd, input int rs1, input int rs2);
        putWord(encR(isSub ? 7'b0100000 : 7'b0000000, rs2[4:0], rs1[4:0], f3, rd[4:0]));
        expectRetire(name, rd, expectedAlu(f3, isSub, shadow[rs1[4:0]], shadow[rs2[4:0]]));
    endtask

    task automatic doLui(input string name, input int rd, input logic [19:0] upper);
        putWord({upper, rd[4:0], 7'b0110111});
        expectRetire(name, rd, {upper, 12'h000});
    endtask

    // offset 12 jumps over exactly the two following slots
    task automatic doBranch(input string name, input logic isNe, input int rs1, input int rs2);
        logic taken;
        if (isNe) begin
            taken = shadow[rs1[4:0]] != shadow[rs2[4:0]];
        end else begin
            taken = shadow[rs1[4:0]] == shadow[rs2[4:0]];
        end
        putWord(encB(13'd12, rs2[4:0], rs1[4:0], isNe ? 3'b001 : 3'b000));
        if (taken) begin
            putWord(encI(12'h0a5, 5'd0, 3'b000, 5'd30));
            putWord(encI(12'h05a, 5'd0, 3'b000, 5'd30));
        end else begin
            doImm({name, " slot 1"}, 3'b000, 30, 0, 'h0a5);
            doImm({name, " slot 2"}, 3'b000, 30, 0, 'h05a);
        end
    endtask

    task automatic doJal(input string name, input int rd);
        logic [31:0] link;
        link = (progLen << 2) + 32'd4;
        putWord(encJ(21'd12, rd[4:0]));
        expectRetire(name, rd, link);
        putWord(encI(12'h0a5, 5'd0, 3'b000, 5'd30));
        putWord(encI(12'h05a, 5'd0, 3'b000, 5'd30));
    endtask

    task automatic buildProgram();
        doImm("addi x1 random", 3'b000, 1, 0, $random(seed));
        doImm("addi x2 random", 3'b000, 2, 0, $random(seed));
        doImm("addi x3 random", 3'b000, 3, 0, $random(seed));
        doImm("andi", 3'b111, 4, 1, 'h0f0);
        doImm("ori", 3'b110, 5, 2, 'h30c);
        doImm("xori all ones", 3'b100, 6, 3, -1);
        doImm("addi negative", 3'b000, 9, 0, -100);
        doImm("slti random vs -3", 3'b010, 7, 1, -3);
        doImm("slti zero vs -3", 3'b010, 8, 0, -3);
        doImm("slti -100 vs -3", 3'b010, 10, 9, -3);
        doImm("addi shift amount", 3'b000, 18, 0, 5);
        doReg("add", 3'b000, 1'b0, 11, 1, 2);
        doReg("sub", 3'b000, 1'b1, 12, 1, 2);
        doReg("and", 3'b111, 1'b0, 13, 4, 5);
        doReg("or", 3'b110, 1'b0, 14, 5, 6);
        doReg("xor", 3'b100, 1'b0, 15, 1, 3);
        doReg("slt signed", 3'b010, 1'b0, 16, 9, 1);
        doReg("sll", 3'b001, 1'b0, 17, 1, 18);
        doReg("srl logical", 3'b101, 1'b0, 19, 9, 18);
        doLui("lui", 20, 20'habcde);
        doImm("addi on lui", 3'b000, 20, 20, 'h123);
        // distance 1 uses the writeback forward, distance 2 the register file bypass
        doImm("fwd d1 producer", 3'b000, 21, 0, 7);
        doReg("fwd d1 consumer", 3'b000, 1'b0, 22, 21, 21);
        doImm("fwd d2 producer", 3'b000, 23, 0, 9);
        doImm("fwd d2 spacer", 3'b000, 24, 0, 1);
        doReg("fwd d2 consumer", 3'b000, 1'b0, 25, 23, 23);
        doImm("fwd d3 producer", 3'b000, 26, 0, 13);
        doImm("fwd d3 spacer a", 3'b000, 27, 0, 2);
        doImm("fwd d3 spacer b", 3'b000, 28, 0, 3);
        doReg("fwd d3 consumer", 3'b000, 1'b0, 29, 26, 26);
        doImm("chain step 1", 3'b000, 21, 21, 1);
        doImm("chain step 2", 3'b000, 21, 21, 1);
        doImm("chain step 3", 3'b000, 21, 21, 1);
        doReg("chain mixed sub", 3'b000, 1'b1, 22, 21, 25);
        doBranch("beq taken", 1'b0, 21, 21);
        doImm("beq taken target", 3'b000, 31, 0, 1);
        doBranch("bne taken", 1'b1, 21, 22);
        doImm("bne taken target", 3'b000, 31, 0, 2);
        doBranch("beq not taken", 1'b0, 21, 22);
        doImm("after beq not taken", 3'b000, 31, 0, 3);
        doBranch("bne not taken", 1'b1, 0, 0);
        doImm("after bne not taken", 3'b000, 31, 0, 4);
        // stale x24 would be 1 and fall through
        doImm("branch operand producer", 3'b000, 24, 0, 9);
        doBranch("beq on forwarded operand", 1'b0, 24, 23);
        doImm("forwarded beq target", 3'b000, 31, 0, 5);
        doJal("jal link", 26);
        doImm("jal target reads link", 3'b000, 27, 26, 0);
        doImm("write x0 retires zero", 3'b000, 0, 0, 'h55);
        doReg("read x0 after write", 3'b000, 1'b0, 28, 0, 1);
    endtask

    // pc sits at the reset vector and nothing retires while reset is held
    task automatic checkResetState();
        assert (pc == 32'h0 && retireValid == 1'b0) begin
            $display("PASS reset state: pc = 0x%08h, retireValid = %0b", pc, retireValid);
            passCount++;
        end else begin
            $display("FAIL reset state: expected pc = 0x%08h retireValid = 0, %s",
                     32'h0, $sformatf("actual pc = 0x%08h retireValid = %0b",
                                      pc, retireValid));
            failCount++;
        end
    endtask

    task automatic checkRetires();
        int       waited;
        retireRow row;
        for (int i = 0; i < expected.size(); i++) begin
            row    = expected[i];
            waited = 0;
            do begin
                @(negedge clock);
                waited++;
            end while (!retireValid && waited < TimeoutCycles);
            if (!retireValid) begin
                $display("timeout: no retire seen within %0d cycles while waiting for %s",
                         TimeoutCycles, testNames[i]);
                failCount++;
                break;
            end
            assert (retireRd == row.rd && retireData == row.data) begin
                $display("PASS %s: x%0d = 0x%08h", testNames[i], retireRd, retireData);
                passCount++;
            end else begin
                $display("FAIL %s: expected x%0d = 0x%08h, actual x%0d = 0x%08h",
                         testNames[i], row.rd, row.data, retireRd, retireData);
                failCount++;
            end
        end
    endtask

    initial begin
        seed      = 32'hc13d;
        passCount = 0;
        failCount = 0;
        progLen   = 0;
        rstN      = 1'b0;
        inst      = Nop;
        shadow    = '{default: '0};
        buildProgram();
        repeat (16) @(posedge clock);
        @(negedge clock);
        checkResetState();
        rstN = 1'b1;
        checkRetires();
        $display("%0d tests, %0d passed, %0d failed", passCount + failCount, passCount,
                 failCount);
        if (failCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
logic/coreIsaPkg.sv
logic/corePipePkg.sv
logic/fetchUnit.sv
logic/decodeUnit.sv
logic/executeUnit.sv
logic/resultUnit.sv
logic/fireCore.sv
tests/coreTb.sv

/* Makefile */
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module coreTb

sim:
	verilator --binary --timing --assert -f sources.f --top-module coreTb \
		--Mdir obj_dir -o coreSim
	./obj_dir/coreSim | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
